// ==== design/srtc_pkg.sv ====
package srtc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Time image, one BCD digit per nibble
  ////////////////////////////////////////////////////////////////////////////

  // First member sits at the top, so sec_one ends up at bits 3:0
  typedef struct packed {
    logic [3:0] wday;
    logic [3:0] cent_ten;
    logic [3:0] cent_one;
    logic [3:0] year_ten;
    logic [3:0] year_one;
    logic [3:0] month_ten;
    logic [3:0] month_one;
    logic [3:0] day_ten;
    logic [3:0] day_one;
    logic [3:0] hour_ten;
    logic [3:0] hour_one;
    logic [3:0] min_ten;
    logic [3:0] min_one;
    logic [3:0] sec_ten;
    logic [3:0] sec_one;
  } rtc_time_t;

  ////////////////////////////////////////////////////////////////////////////
  // Port state and control commands
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    ST_READ     = 3'd1,
    ST_COMMAND  = 3'd2,
    ST_WRITE    = 3'd3,
    ST_WAIT_ACK = 3'd4
  } srtc_state_e;

  typedef enum logic [3:0] {
    CMD_LOAD       = 4'h0,
    CMD_STOP       = 4'h4,
    CMD_READ_RESET = 4'hd,
    CMD_PREFIX     = 4'he
  } srtc_cmd_e;

  // One-cycle host access, already filtered and synchronized
  typedef struct packed {
    logic       wr_evt;
    logic       rd_evt;
    logic       addr;
    logic [3:0] data;
  } srtc_bus_evt_t;

  // Pointer value that takes the read snapshot
  localparam logic [3:0] PTR_LATCH = 4'd15;
  // Last nibble before the closing 0x0f
  localparam logic [3:0] PTR_LAST = 4'd12;

endpackage

// ==== design/srtc_bus_sync.sv ====
`timescale 1ns/1ps

module srtc_bus_sync (
  input  logic                    clkin,
  input  logic                    reset_rising,
  input  logic                    enable,
  input  logic                    addr_in,
  input  logic [3:0]              data_in,
  input  logic                    reg_we,
  input  logic                    reg_oe,
  output srtc_pkg::srtc_bus_evt_t bus_evt
);

  // First sample of the asynchronous host lines
  logic       we_s;
  logic       oe_s;
  logic       en_s;
  logic [3:0] data_s;

  logic [5:0] we_sreg;
  logic [5:0] oe_sreg;
  logic [3:0] addr_dly;
  logic [3:0] data_hold;

  logic we_rise;
  logic oe_fall;

  always_ff @(posedge clkin) begin
    if (reset_rising) begin
      we_s    <= 1'b1;
      oe_s    <= 1'b1;
      en_s    <= 1'b0;
      we_sreg <= 6'h3f;
      oe_sreg <= 6'h3f;
    end else begin
      we_s    <= reg_we;
      oe_s    <= reg_oe;
      en_s    <= enable;
      we_sreg <= {we_sreg[4:0], we_s};
      oe_sreg <= {oe_sreg[4:0], oe_s};
    end
  end

  // Address delay and data capture while the write strobe is low
  always_ff @(posedge clkin) begin
    data_s   <= data_in;
    addr_dly <= {addr_dly[2:0], addr_in};
    if (!we_s) begin
      data_hold <= data_s;
    end
  end

  // New level in bit 1, four older samples at the old level above it
  assign we_rise = (we_sreg[5:1] == 5'b00001);
  assign oe_fall = (oe_sreg[5:1] == 5'b11110);

  always_ff @(posedge clkin) begin
    if (reset_rising) begin
      bus_evt.wr_evt <= 1'b0;
      bus_evt.rd_evt <= 1'b0;
    end else begin
      bus_evt.wr_evt <= we_rise & en_s;
      bus_evt.rd_evt <= oe_fall & en_s;
    end
    bus_evt.addr <= addr_dly[3];
    bus_evt.data <= data_hold;
  end

  // The two strobes must never produce events together
  assert property (@(posedge clkin) disable iff (reset_rising)
    !(bus_evt.wr_evt && bus_evt.rd_evt))
    else $error("write and read events in the same cycle");

endmodule

// ==== design/srtc_port.sv ====
`timescale 1ns/1ps

module srtc_port (
  input  logic                    clkin,
  input  logic                    reset_rising,
  input  srtc_pkg::srtc_bus_evt_t bus_evt,
  input  srtc_pkg::rtc_time_t     cur_time,
  output logic [7:0]              data_out,
  output logic                    load_req,
  output srtc_pkg::rtc_time_t     load_time,
  input  logic                    load_ack
);

  srtc_pkg::srtc_state_e state;
  srtc_pkg::srtc_cmd_e   cmd;
  logic [3:0]            ptr;
  srtc_pkg::rtc_time_t   snap;
  srtc_pkg::rtc_time_t   store_time;
  logic [7:0]            rd_byte;

  logic wr_ctrl;
  logic rd_data;
  logic is_cmd;
  logic load_copy;
  logic store_nib;
  logic snap_take;

  // Binary 0..19 to a BCD pair, tens digit offset by ten_base
  function automatic logic [7:0] fold_bcd(input logic [3:0] v, input logic [3:0] ten_base);
    logic [3:0] ten;
    logic [3:0] one;
    if (v < 4'd10) begin
      ten = ten_base;
      one = v;
    end else begin
      ten = ten_base + 4'd1;
      one = v - 4'd10;
    end
    return {ten, one};
  endfunction

  // Inverse of fold_bcd
  function automatic logic [7:0] unfold_bcd(input logic [3:0] ten, input logic [3:0] one,
                                            input logic [3:0] ten_base);
    logic [7:0] tens;
    tens = {4'h0, ten - ten_base};
    return tens * 8'd10 + {4'h0, one};
  endfunction

  assign cmd = srtc_pkg::srtc_cmd_e'(bus_evt.data);

  ////////////////////////////////////////////////////////////////////////////
  // Event decode
  ////////////////////////////////////////////////////////////////////////////

  // Writes are dropped while a load is in flight
  assign wr_ctrl = bus_evt.wr_evt && bus_evt.addr && (state != srtc_pkg::ST_WAIT_ACK);
  assign rd_data = bus_evt.rd_evt && !bus_evt.addr;
  assign is_cmd  = (cmd == srtc_pkg::CMD_READ_RESET) || (cmd == srtc_pkg::CMD_PREFIX);

  assign load_copy = wr_ctrl && !is_cmd && (state == srtc_pkg::ST_COMMAND)
                     && (cmd == srtc_pkg::CMD_LOAD);
  assign store_nib = wr_ctrl && !is_cmd && (state == srtc_pkg::ST_WRITE)
                     && (ptr <= srtc_pkg::PTR_LAST);
  assign snap_take = rd_data && (state == srtc_pkg::ST_READ)
                     && (ptr == srtc_pkg::PTR_LATCH);

  // Image with the incoming nibble placed at the pointer
  always_comb begin
    store_time = load_time;
    case (ptr)
      4'd0:  store_time.sec_one  = bus_evt.data;
      4'd1:  store_time.sec_ten  = bus_evt.data;
      4'd2:  store_time.min_one  = bus_evt.data;
      4'd3:  store_time.min_ten  = bus_evt.data;
      4'd4:  store_time.hour_one = bus_evt.data;
      4'd5:  store_time.hour_ten = bus_evt.data;
      4'd6:  store_time.day_one  = bus_evt.data;
      4'd7:  store_time.day_ten  = bus_evt.data;
      4'd8:  {store_time.month_ten, store_time.month_one} = fold_bcd(bus_evt.data, 4'd0);
      4'd9:  store_time.year_one = bus_evt.data;
      4'd10: store_time.year_ten = bus_evt.data;
      4'd11: {store_time.cent_ten, store_time.cent_one} = fold_bcd(bus_evt.data, 4'd1);
      4'd12: store_time.wday     = bus_evt.data;
      default: ;
    endcase
  end

  // Read-out nibble from the snapshot, 0x0f outside the data range
  always_comb begin
    case (ptr)
      4'd0:  rd_byte = {4'h0, snap.sec_one};
      4'd1:  rd_byte = {4'h0, snap.sec_ten};
      4'd2:  rd_byte = {4'h0, snap.min_one};
      4'd3:  rd_byte = {4'h0, snap.min_ten};
      4'd4:  rd_byte = {4'h0, snap.hour_one};
      4'd5:  rd_byte = {4'h0, snap.hour_ten};
      4'd6:  rd_byte = {4'h0, snap.day_one};
      4'd7:  rd_byte = {4'h0, snap.day_ten};
      4'd8:  rd_byte = unfold_bcd(snap.month_ten, snap.month_one, 4'd0);
      4'd9:  rd_byte = {4'h0, snap.year_one};
      4'd10: rd_byte = {4'h0, snap.year_ten};
      4'd11: rd_byte = unfold_bcd(snap.cent_ten, snap.cent_one, 4'd1);
      4'd12: rd_byte = {4'h0, snap.wday};
      default: rd_byte = 8'h0f;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Command and pointer FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (reset_rising) begin
      state    <= srtc_pkg::ST_READ;
      ptr      <= srtc_pkg::PTR_LATCH;
      data_out <= 8'h00;
      load_req <= 1'b0;
    end else if (state == srtc_pkg::ST_WAIT_ACK) begin
      if (rd_data) begin
        data_out <= 8'h00;
      end
      // Four-phase handshake with the timekeeper
      if (load_req && load_ack) begin
        load_req <= 1'b0;
      end else if (!load_req && !load_ack) begin
        state <= srtc_pkg::ST_WRITE;
      end
    end else if (wr_ctrl) begin
      case (cmd)
        srtc_pkg::CMD_READ_RESET: begin
          state <= srtc_pkg::ST_READ;
          ptr   <= srtc_pkg::PTR_LATCH;
        end
        srtc_pkg::CMD_PREFIX: state <= srtc_pkg::ST_COMMAND;
        default: begin
          if (load_copy) begin
            state <= srtc_pkg::ST_WRITE;
            ptr   <= 4'd0;
          end else if (state == srtc_pkg::ST_COMMAND) begin
            state <= srtc_pkg::ST_IDLE;
            if (cmd == srtc_pkg::CMD_STOP) begin
              ptr <= srtc_pkg::PTR_LATCH;
            end
          end else if (store_nib) begin
            ptr      <= ptr + 4'd1;
            state    <= srtc_pkg::ST_WAIT_ACK;
            load_req <= 1'b1;
          end
        end
      endcase
    end else if (rd_data) begin
      if (state == srtc_pkg::ST_READ) begin
        data_out <= rd_byte;
        // 13 closes the frame and rearms the snapshot
        ptr <= (ptr == srtc_pkg::PTR_LAST + 4'd1) ? srtc_pkg::PTR_LATCH : ptr + 4'd1;
      end else begin
        data_out <= 8'h00;
      end
    end
  end

  // Load image and read snapshot
  always_ff @(posedge clkin) begin
    if (load_copy) begin
      load_time <= cur_time;
    end else if (store_nib) begin
      load_time <= store_time;
    end
    if (snap_take) begin
      snap <= cur_time;
    end
  end

  // Request is held until the timekeeper acknowledges
  assert property (@(posedge clkin) disable iff (reset_rising)
    load_req && !load_ack |=> load_req)
    else $error("load_req dropped before load_ack");

endmodule

// ==== design/rtc_timekeeper.sv ====
`timescale 1ns/1ps

module rtc_timekeeper #(
  parameter int TICKS_PER_SEC = 21477000
) (
  input  logic                clkin,
  input  logic                reset_rising,
  input  logic                load_req,
  input  srtc_pkg::rtc_time_t load_time,
  output logic                load_ack,
  output srtc_pkg::rtc_time_t cur_time
);

  localparam int CNT_W = (TICKS_PER_SEC > 2) ? $clog2(TICKS_PER_SEC) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICKS_PER_SEC - 1);

  // Day 01, month 01, century 19, all else zero
  localparam srtc_pkg::rtc_time_t TIME_RESET = '{
    cent_ten:  4'd1,
    cent_one:  4'd9,
    month_one: 4'd1,
    day_one:   4'd1,
    default:   4'd0
  };

  logic [CNT_W-1:0]    presc;
  logic                tick;
  srtc_pkg::rtc_time_t next_time;

  logic       sec_c;
  logic       min_c;
  logic       hour_c;
  logic [7:0] sec_v;
  logic [7:0] min_v;
  logic [7:0] hour_v;
  logic [7:0] day_v;

  // BCD increment of a two-digit value, no wrap
  function automatic logic [7:0] bcd_inc(input logic [7:0] v);
    if (v[3:0] == 4'd9) begin
      return {v[7:4] + 4'd1, 4'd0};
    end
    return {v[7:4], v[3:0] + 4'd1};
  endfunction

  assign tick = (presc == CNT_LAST);

  assign sec_v  = {cur_time.sec_ten, cur_time.sec_one};
  assign min_v  = {cur_time.min_ten, cur_time.min_one};
  assign hour_v = {cur_time.hour_ten, cur_time.hour_one};
  assign day_v  = {cur_time.day_ten, cur_time.day_one};

  ////////////////////////////////////////////////////////////////////////////
  // One-second step of the calendar counters
  ////////////////////////////////////////////////////////////////////////////

  assign sec_c  = (sec_v == 8'h59);
  assign min_c  = sec_c && (min_v == 8'h59);
  assign hour_c = min_c && (hour_v == 8'h23);

  always_comb begin
    next_time = cur_time;
    {next_time.sec_ten, next_time.sec_one} = sec_c ? 8'h00 : bcd_inc(sec_v);
    if (sec_c) begin
      {next_time.min_ten, next_time.min_one} = (min_v == 8'h59) ? 8'h00 : bcd_inc(min_v);
    end
    if (min_c) begin
      {next_time.hour_ten, next_time.hour_one} = (hour_v == 8'h23) ? 8'h00 : bcd_inc(hour_v);
    end
    // Day carry, month and year stay as written
    if (hour_c) begin
      {next_time.day_ten, next_time.day_one} = (day_v == 8'h31) ? 8'h01 : bcd_inc(day_v);
      next_time.wday = (cur_time.wday == 4'd6) ? 4'd0 : cur_time.wday + 4'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Prescaler, time register and load acknowledge
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (reset_rising) begin
      presc    <= '0;
      cur_time <= TIME_RESET;
      load_ack <= 1'b0;
    end else if (load_req && !load_ack) begin
      // New image, second restarts from here
      cur_time <= load_time;
      presc    <= '0;
      load_ack <= 1'b1;
    end else begin
      if (!load_req) begin
        load_ack <= 1'b0;
      end
      if (tick) begin
        presc    <= '0;
        cur_time <= next_time;
      end else begin
        presc <= presc + 1'b1;
      end
    end
  end

  // Acknowledge only answers a pending request
  assert property (@(posedge clkin) disable iff (reset_rising)
    $rose(load_ack) |-> $past(load_req))
    else $error("load_ack rose without load_req");

endmodule

// ==== design/srtc_top.sv ====
`timescale 1ns/1ps

module srtc_top #(
  parameter int TICKS_PER_SEC = 21477000
) (
  input  logic                clkin,
  input  logic                reset_rising,
  input  logic                enable,
  input  logic                addr_in,
  input  logic [3:0]          data_in,
  input  logic                reg_we,
  input  logic                reg_oe,
  output logic [7:0]          data_out,
  output srtc_pkg::rtc_time_t time_out
);

  srtc_pkg::srtc_bus_evt_t bus_evt;
  srtc_pkg::rtc_time_t     load_time;
  logic                    load_req;
  logic                    load_ack;

  // Host strobes into single-cycle events
  srtc_bus_sync srtc_bus_sync_i (
    .clkin        (clkin),
    .reset_rising (reset_rising),
    .enable       (enable),
    .addr_in      (addr_in),
    .data_in      (data_in),
    .reg_we       (reg_we),
    .reg_oe       (reg_oe),
    .bus_evt      (bus_evt)
  );

  srtc_port srtc_port_i (
    .clkin        (clkin),
    .reset_rising (reset_rising),
    .bus_evt      (bus_evt),
    .cur_time     (time_out),
    .data_out     (data_out),
    .load_req     (load_req),
    .load_time    (load_time),
    .load_ack     (load_ack)
  );

  // Running time, also the top-level output
  rtc_timekeeper #(
    .TICKS_PER_SEC (TICKS_PER_SEC)
  ) rtc_timekeeper_i (
    .clkin        (clkin),
    .reset_rising (reset_rising),
    .load_req     (load_req),
    .load_time    (load_time),
    .load_ack     (load_ack),
    .cur_time     (time_out)
  );

endmodule

// ==== verif/srtc_tb.sv ====
`timescale 1ns/1ps

module srtc_tb;

  localparam int TICKS = 1000;
  // Wide margin over the roughly 3000 cycles of the tests
  localparam int MAX_CYCLES = 20000;

  logic                clkin;
  logic                reset_rising;
  logic                enable;
  logic                addr_in;
  logic [3:0]          data_in;
  logic                reg_we;
  logic                reg_oe;
  logic [7:0]          data_out;
  srtc_pkg::rtc_time_t time_out;

  // Host view of the time with one nibble per pointer position
  logic [3:0]          nib [0:12];
  logic                rd_check;
  logic [7:0]          rd_exp;
  string               test_name;
  int                  cycle_cnt = 0;
  srtc_pkg::rtc_time_t loaded;
  srtc_pkg::rtc_time_t rolled;
  logic [3:0]          stray;

  srtc_top #(
    .TICKS_PER_SEC (TICKS)
  ) srtc_top_i (
    .clkin        (clkin),
    .reset_rising (reset_rising),
    .enable       (enable),
    .addr_in      (addr_in),
    .data_in      (data_in),
    .reg_we       (reg_we),
    .reg_oe       (reg_oe),
    .data_out     (data_out),
    .time_out     (time_out)
  );

  initial begin
    clkin = 1'b0;
    forever #10 clkin = ~clkin;
  end

  always @(posedge clkin) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read-back check 5 cycles after the strobe falls
  ////////////////////////////////////////////////////////////////////////////

  property read_value_p;
    @(posedge clkin) disable iff (reset_rising)
      $fell(reg_oe) && rd_check |-> ##5 (data_out == rd_exp);
  endproperty

  read_value_a: assert property (read_value_p)
    else begin
      $display("ERROR: %s: expected data_out %02h, actual %02h", test_name, rd_exp, data_out);
      $display("Simulation FAILED");
      $fatal(1, "read value mismatch");
    end

  // Expected time image with month and century folded to BCD
  function automatic srtc_pkg::rtc_time_t make_image();
    srtc_pkg::rtc_time_t t;
    logic [4:0]          cent;
    cent        = 5'd10 + {1'b0, nib[11]};
    t.sec_one   = nib[0];
    t.sec_ten   = nib[1];
    t.min_one   = nib[2];
    t.min_ten   = nib[3];
    t.hour_one  = nib[4];
    t.hour_ten  = nib[5];
    t.day_one   = nib[6];
    t.day_ten   = nib[7];
    t.month_ten = (nib[8] >= 4'd10) ? 4'd1 : 4'd0;
    t.month_one = (nib[8] >= 4'd10) ? nib[8] - 4'd10 : nib[8];
    t.year_one  = nib[9];
    t.year_ten  = nib[10];
    t.cent_ten  = 4'(cent / 5'd10);
    t.cent_one  = 4'(cent % 5'd10);
    t.wday      = nib[12];
    return t;
  endfunction

  // Frame is 0x0f, nibbles 0..12, then 0x0f
  function automatic logic [7:0] frame_byte(input int i);
    if (i >= 1 && i <= 13) begin
      return {4'h0, nib[i-1]};
    end
    return 8'h0f;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clkin);
  endtask

  task automatic bus_write(input logic a, input logic [3:0] value);
    addr_in = a;
    data_in = value;
    reg_we  = 1'b0;
    wait_cycles(8);
    reg_we = 1'b1;
    wait_cycles(8);
  endtask

  task automatic bus_read(input logic a);
    addr_in  = a;
    rd_check = (a == 1'b0);
    // Address settles before the strobe falls
    wait_cycles(1);
    reg_oe = 1'b0;
    wait_cycles(8);
    reg_oe = 1'b1;
    wait_cycles(8);
  endtask

  task automatic load_nibbles(input int count);
    bus_write(1'b1, srtc_pkg::CMD_PREFIX);
    bus_write(1'b1, srtc_pkg::CMD_LOAD);
    for (int k = 0; k < count; k++) begin
      bus_write(1'b1, nib[k]);
    end
  endtask

  task automatic read_frame(input int count);
    for (int i = 0; i < count; i++) begin
      rd_exp = frame_byte(i);
      bus_read(1'b0);
    end
  endtask

  task automatic check_time(input srtc_pkg::rtc_time_t exp);
    assert (time_out === exp) else begin
      $display("ERROR: %s: expected time %015h, actual %015h", test_name, exp, time_out);
      $display("Simulation FAILED");
      $fatal(1, "time mismatch");
    end
  endtask

  // Legal random time with the century clear of the command codes
  task automatic random_time();
    int h;
    int d;
    h       = $urandom % 24;
    d       = 1 + $urandom % 31;
    nib[0]  = 4'($urandom % 10);
    nib[1]  = 4'($urandom % 6);
    nib[2]  = 4'($urandom % 10);
    nib[3]  = 4'($urandom % 6);
    nib[4]  = 4'(h % 10);
    nib[5]  = 4'(h / 10);
    nib[6]  = 4'(d % 10);
    nib[7]  = 4'(d / 10);
    nib[8]  = 4'(1 + $urandom % 12);
    nib[9]  = 4'($urandom % 10);
    nib[10] = 4'($urandom % 10);
    nib[11] = 4'(9 + $urandom % 4);
  endtask

  // Day 01, month 01, century 19
  task automatic set_reset_model();
    for (int k = 0; k <= 12; k++) begin
      nib[k] = 4'd0;
    end
    nib[6]  = 4'd1;
    nib[8]  = 4'd1;
    nib[11] = 4'd9;
  endtask

  task automatic apply_reset();
    reset_rising = 1'b1;
    wait_cycles(4);
    reset_rising = 1'b0;
    wait_cycles(2);
  endtask

  task automatic measure_rollover(input srtc_pkg::rtc_time_t ld, input srtc_pkg::rtc_time_t nx);
    int n;
    n = 0;
    while (time_out !== ld && n < 100) begin
      @(negedge clkin);
      n++;
    end
    check_time(ld);
    n = 0;
    while (time_out !== nx && n < 1200) begin
      @(negedge clkin);
      n++;
    end
    assert (n >= 1000 && n <= 1100) else begin
      $display("ERROR: %s: expected rollover after 1000 to 1100 cycles, actual %0d",
               test_name, n);
      $display("Simulation FAILED");
      $fatal(1, "rollover timing");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset_rising = 1'b1;
    enable       = 1'b1;
    addr_in      = 1'b0;
    data_in      = 4'h0;
    reg_we       = 1'b1;
    reg_oe       = 1'b1;
    rd_check     = 1'b0;
    rd_exp       = 8'h00;
    test_name    = "reset_values";
    void'($urandom(32'h81661674));
    wait_cycles(4);
    reset_rising = 1'b0;
    wait_cycles(2);
    set_reset_model();
    check_time(make_image());

    test_name = "load_readback";
    random_time();
    load_nibbles(12);
    check_time(make_image());
    bus_write(1'b1, srtc_pkg::CMD_READ_RESET);
    read_frame(15);

    test_name = "folding";
    random_time();
    nib[8]  = 4'd12;
    nib[11] = 4'd10;
    load_nibbles(12);
    check_time(make_image());
    assert ({time_out.month_ten, time_out.month_one, time_out.cent_ten, time_out.cent_one}
            == 16'h1220) else begin
      $display("ERROR: %s: expected month/century 1220, actual %02h%02h", test_name,
               {time_out.month_ten, time_out.month_one}, {time_out.cent_ten, time_out.cent_one});
      $display("Simulation FAILED");
      $fatal(1, "folding mismatch");
    end
    bus_write(1'b1, srtc_pkg::CMD_READ_RESET);
    read_frame(15);

    // Reset partway through a frame
    test_name = "reset_mid_read";
    bus_write(1'b1, srtc_pkg::CMD_READ_RESET);
    read_frame(1);
    apply_reset();
    set_reset_model();
    check_time(make_image());
    assert (data_out == 8'h00) else begin
      $display("ERROR: %s: expected data_out 00, actual %02h", test_name, data_out);
      $display("Simulation FAILED");
      $fatal(1, "data_out after reset");
    end
    rd_exp = 8'h0f;
    bus_read(1'b0);

    test_name = "time_advance";
    nib = '{4'd9, 4'd5, 4'd9, 4'd5, 4'd3, 4'd2, 4'd1, 4'd3, 4'd6, 4'd4, 4'd2, 4'd10, 4'd6};
    loaded = make_image();
    rolled = loaded;
    {rolled.hour_ten, rolled.hour_one, rolled.min_ten, rolled.min_one} = 16'h0000;
    {rolled.sec_ten, rolled.sec_one} = 8'h00;
    {rolled.day_ten, rolled.day_one} = 8'h01;
    rolled.wday = 4'd0;
    load_nibbles(12);
    fork
      bus_write(1'b1, nib[12]);
      measure_rollover(loaded, rolled);
    join

    // Strobes while disabled must not reach the port
    test_name = "mode_rules";
    enable = 1'b0;
    wait_cycles(2);
    bus_write(1'b1, srtc_pkg::CMD_PREFIX);
    bus_write(1'b1, srtc_pkg::CMD_LOAD);
    bus_write(1'b1, 4'h5);
    bus_write(1'b1, 4'h3);
    enable = 1'b1;
    wait_cycles(2);
    check_time(rolled);
    bus_write(1'b1, srtc_pkg::CMD_PREFIX);
    bus_write(1'b1, srtc_pkg::CMD_STOP);
    rd_exp = 8'h00;
    bus_read(1'b0);
    bus_write(1'b1, srtc_pkg::CMD_READ_RESET);
    rd_exp = 8'h0f;
    bus_read(1'b0);
    do begin
      stray = 4'($urandom);
    end while (stray == 4'h0 || stray == 4'hd || stray == 4'he);
    bus_write(1'b1, srtc_pkg::CMD_PREFIX);
    bus_write(1'b1, stray);
    rd_exp = 8'h00;
    bus_read(1'b0);
    bus_write(1'b1, srtc_pkg::CMD_READ_RESET);
    rd_exp = 8'h0f;
    bus_read(1'b0);

    wait_cycles(4);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
design/srtc_pkg.sv
design/srtc_bus_sync.sv
design/srtc_port.sv
design/rtc_timekeeper.sv
design/srtc_top.sv
verif/srtc_tb.sv

// ==== Bender.yml ====
package:
  name: srtc

sources:
  - design/srtc_pkg.sv
  - design/srtc_bus_sync.sv
  - design/srtc_port.sv
  - design/rtc_timekeeper.sv
  - design/srtc_top.sv
  - target: simulation
    files:
      - verif/srtc_tb.sv
